// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys -f compile.f
	out=$$(./obj_dir/Vtb_mem_subsys); echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: compile.f
verilog/mem_subsys_pkg.sv
verilog/mem_misalign_check.sv
verilog/mem_port_arbiter.sv
verilog/mem_data_lane.sv
verilog/mem_sram.sv
verilog/mem_subsys_top.sv
sim/tb_mem_subsys.sv

// File: sim/tb_mem_subsys.sv
// --------------------------------------------------
// Memory subsystem testbench
// Drives both ports against a byte reference model
// and checks the responses with assertions.
// --------------------------------------------------

`timescale 1ns/1ns

module tb_mem_subsys
  import mem_subsys_pkg::*;
;

  localparam int N_ACC = 32 + 60 + 40 + 30 + 200;  // Planned accesses.

  logic clk_i, rst_n_i;
  logic fetch_req_i, fetch_ack_o, fetch_err_o;
  logic [XLEN-1:0] fetch_adr_i, fetch_rdata_o;
  logic data_req_i, data_we_i, data_unsigned_i, data_ack_o, data_err_o;
  access_size_e data_size_i;
  logic [XLEN-1:0] data_adr_i, data_wdata_i, data_rdata_o;

  logic [7:0] ref_mem [2048];           // Byte image of the low 2 KiB.
  bit         ref_known [2048];         // Byte has been written.
  logic [63:0] d_exp, d_mask, f_exp, f_mask;
  bit d_exp_err, f_exp_err;
  bit lone;                             // Only one port active.
  int d_wait, f_wait;                   // Cycles spent waiting.
  int mismatch_cnt, fail_cnt;
  int cyc;                              // Clock cycle count.
  int d_req_cyc, f_req_cyc;             // Cycle in which each request appeared.
  bit win_data;                         // Data port should win the next tie.
  logic both_new;                       // Both ports raised a request together.

  mem_subsys_top #(.HAS_RVC(1)) DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    d_wait <= (!data_req_i || data_ack_o) ? 0 : d_wait + 1;
    f_wait <= (!fetch_req_i || fetch_ack_o) ? 0 : f_wait + 1;
  end

  // A tie needs both requests new in the same cycle.
  assign both_new = data_req_i && fetch_req_i && d_req_cyc == cyc && f_req_cyc == cyc;

  // Ties alternate between the ports, fetch first.
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (both_new) begin
      win_data <= !win_data;
    end
  end

  // Expected read value and mask of checked bits.
  function automatic void expect_read(input logic [63:0] adr, input int n, input bit sext,
                                      input bit fetch, output logic [63:0] e,
                                      output logic [63:0] m);
    int a;
    e = '0;
    m = '0;
    for (int i = 0; i < n; i++) begin
      a = int'(adr[10:0]) + i;
      if (fetch && int'(adr[2:0]) + i > 7) begin
        m[8*i +: 8] = 8'hff;            // Past the doubleword, reads zero.
      end else begin
        e[8*i +: 8] = ref_mem[a];
        m[8*i +: 8] = ref_known[a] ? 8'hff : 8'h00;
      end
    end
    for (int k = 8 * n; k < 64; k++) begin
      e[k] = sext ? e[8*n-1] : 1'b0;
      m[k] = sext ? m[8*n-1] : 1'b1;
    end
  endfunction

  task automatic data_access(input bit we, input bit uns, input int size,
                             input logic [63:0] adr, input logic [63:0] wdata, input bit drop);
    int n;
    int waited;
    bit err;
    logic [63:0] e, m;
    n = (size < 4) ? (1 << size) : 1;
    err = (size > 3) || (adr % n != 0);
    e = '0;
    m = '1;
    if (!err && we) m = '0;             // Store data is not returned.
    else if (!err) expect_read(adr, n, !uns, 1'b0, e, m);
    @(negedge clk_i);
    d_exp = e;
    d_mask = m;
    d_exp_err = err;
    data_req_i = 1'b1;
    data_we_i = we;
    data_unsigned_i = uns;
    data_size_i = access_size_e'(size);
    data_adr_i = adr;
    data_wdata_i = wdata;
    d_req_cyc = cyc;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!data_ack_o && waited < 20);
    if (!data_ack_o) begin
      fail_cnt++;
      $display("Data port was never acknowledged at time %0t", $time);
    end else if (we && !err) begin
      for (int i = 0; i < n; i++) begin
        ref_mem[int'(adr[10:0]) + i] = wdata[8*i +: 8];
        ref_known[int'(adr[10:0]) + i] = 1'b1;
      end
    end
    if (drop) begin
      @(negedge clk_i);
      data_req_i = 1'b0;
    end
  endtask

  task automatic fetch_access(input logic [63:0] adr, input bit drop);
    int waited;
    logic [63:0] e, m;
    e = '0;
    m = '1;
    if (!adr[0]) expect_read(adr, 4, 1'b0, 1'b1, e, m);
    @(negedge clk_i);
    f_exp = e;
    f_mask = m;
    f_exp_err = adr[0];                 // Halfword steps with RVC.
    fetch_req_i = 1'b1;
    fetch_adr_i = adr;
    f_req_cyc = cyc;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!fetch_ack_o && waited < 20);
    if (!fetch_ack_o) begin
      fail_cnt++;
      $display("Fetch port was never acknowledged at time %0t", $time);
    end
    if (drop) begin
      @(negedge clk_i);
      fetch_req_i = 1'b0;
    end
  endtask

  // Response checks.
  a_data_val: assert property (@(posedge clk_i)
                               data_ack_o |-> ((data_rdata_o ^ d_exp) & d_mask) == 0)
    else begin
      mismatch_cnt++;
      $display("mismatch at %0t: data_rdata_o expected %h got %h", $time, d_exp,
               $sampled(data_rdata_o));
    end
  a_data_err: assert property (@(posedge clk_i) data_ack_o |-> data_err_o == d_exp_err)
    else begin
      mismatch_cnt++;
      $display("mismatch at %0t: data_err_o expected %b got %b", $time, d_exp_err,
               $sampled(data_err_o));
    end
  a_fetch_val: assert property (@(posedge clk_i)
                                fetch_ack_o |-> ((fetch_rdata_o ^ f_exp) & f_mask) == 0)
    else begin
      mismatch_cnt++;
      $display("mismatch at %0t: fetch_rdata_o expected %h got %h", $time, f_exp,
               $sampled(fetch_rdata_o));
    end
  a_fetch_err: assert property (@(posedge clk_i) fetch_ack_o |-> fetch_err_o == f_exp_err)
    else begin
      mismatch_cnt++;
      $display("mismatch at %0t: fetch_err_o expected %b got %b", $time, f_exp_err,
               $sampled(fetch_err_o));
    end

  // Protocol and timing checks.
  a_reset: assert property (@(posedge clk_i) !rst_n_i |=>
                            !data_ack_o && !fetch_ack_o && !data_err_o && !fetch_err_o)
    else begin
      fail_cnt++;
      $display("Ack or error high right after reset at %0t", $time);
    end
  a_data_lat: assert property (@(posedge clk_i)
                               $rose(data_req_i) && lone |=> !data_ack_o ##1 data_ack_o)
    else begin
      fail_cnt++;
      $display("Lone data request not acked after 2 cycles at %0t", $time);
    end
  a_fetch_lat: assert property (@(posedge clk_i)
                                $rose(fetch_req_i) && lone |=> !fetch_ack_o ##1 fetch_ack_o)
    else begin
      fail_cnt++;
      $display("Lone fetch not acked after 2 cycles at %0t", $time);
    end
  a_data_once: assert property (@(posedge clk_i) data_ack_o |-> data_req_i ##1 !data_ack_o)
    else begin
      fail_cnt++;
      $display("Data ack without request or repeated at %0t", $time);
    end
  a_fetch_once: assert property (@(posedge clk_i) fetch_ack_o |-> fetch_req_i ##1 !fetch_ack_o)
    else begin
      fail_cnt++;
      $display("Fetch ack without request or repeated at %0t", $time);
    end
  a_wait: assert property (@(posedge clk_i) d_wait <= 3 && f_wait <= 3)
    else begin
      fail_cnt++;
      $display("A port waited more than 3 cycles at %0t", $time);
    end
  // Winner of a tie is acknowledged two cycles later.
  a_tie: assert property (@(posedge clk_i) $past(both_new, 2) |->
                          data_ack_o == $past(win_data, 2) && fetch_ack_o != $past(win_data, 2))
    else begin
      fail_cnt++;
      $display("Tied requests were granted in the wrong order at %0t", $time);
    end

  initial begin
    #(N_ACC * 10 * 8);
    $display("Watchdog expired before the tests finished");
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    $display("Test failures found");
    $finish;
  end

  initial begin
    int size;
    int off;
    logic [63:0] base;
    void'($urandom(32'hdc20a609));
    rst_n_i = 1'b0;
    lone = 1'b1;
    d_req_cyc = -1;
    f_req_cyc = -1;
    fetch_req_i = 1'b0;
    fetch_adr_i = '0;
    data_req_i = 1'b0;
    data_we_i = 1'b0;
    data_unsigned_i = 1'b0;
    data_size_i = BYTE;
    data_adr_i = '0;
    data_wdata_i = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    for (int i = 0; i < 32; i++) data_access(1, 0, 3, i * 8, {$urandom, $urandom}, 1);
    repeat (60) begin                   // Aligned stores and loads.
      size = $urandom % 4;
      off = ($urandom % (8 >> size)) << size;
      data_access($urandom % 2, $urandom % 2, size, ($urandom % 64) * 8 + off,
                  {$urandom, $urandom}, 1);
    end
    repeat (20) begin                   // Misaligned or illegal, then reload.
      size = $urandom % 8;
      if (size == 0) size = 4 + $urandom % 4;
      off = $urandom % 8;
      if (size < 4 && off % (1 << size) == 0) off++;
      base = ($urandom % 32) * 8;
      data_access(1, 0, size, base + off, {$urandom, $urandom}, 1);
      data_access(0, 0, 3, base, '0, 1);
    end
    repeat (30) begin                   // Fetches, some odd.
      fetch_access(($urandom % 256) * 2 + (($urandom % 4) == 0), 1);
    end
    lone = 1'b0;
    fork                                // Random gaps keep the ports meeting in ties.
      repeat (100) begin
        size = $urandom % 4;
        data_access($urandom % 2, $urandom % 2, size, 1024 + ($urandom % 128) * 8,
                    {$urandom, $urandom}, $urandom % 2);
      end
      repeat (100) fetch_access(($urandom % 256) * 2, $urandom % 2);
    join
    @(negedge clk_i);
    data_req_i = 1'b0;
    fetch_req_i = 1'b0;
    repeat (4) @(negedge clk_i);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: verilog/mem_data_lane.sv
// --------------------------------------------------
// Memory data lane unit
// Places store bytes into their lanes with strobes
// and extracts load and fetch results.
// --------------------------------------------------

`timescale 1ns/1ns

module mem_data_lane
  import mem_subsys_pkg::*;
(
  // Store side, from the issue register.
  input  access_size_e      iss_size_i,
  input  logic [XLEN-1:0]   iss_adr_i,
  input  logic [XLEN-1:0]   iss_wdata_i,

  // Load side, from the memory capture stage.
  input  logic [XLEN-1:0]   rd_word_i,      // Raw doubleword.
  input  access_size_e      rd_size_i,
  input  logic [2:0]        rd_off_i,       // Byte offset in the doubleword.
  input  logic              rd_instr_i,
  input  logic              rd_unsigned_i,

  output logic [XLEN-1:0]   lane_wdata_o,
  output logic [7:0]        lane_strb_o,
  output logic [XLEN-1:0]   rd_data_o
);

  logic [7:0]      strb_base;  // Strobes at offset zero.
  logic [XLEN-1:0] rd_shift;   // Addressed byte moved to lane 0.
  logic            sext;       // Sign bit to replicate.

  // Store data moves up to its byte offset.
  assign lane_wdata_o = iss_wdata_i << {iss_adr_i[2:0], 3'b000};

  always_comb begin
    case (iss_size_i)
      BYTE:    strb_base = 8'h01;
      HWORD:   strb_base = 8'h03;
      WORD:    strb_base = 8'h0f;
      DWORD:   strb_base = 8'hff;
      default: strb_base = 8'h00;  // Illegal size writes nothing.
    endcase
  end

  // Lanes past byte 7 fall off the top.
  assign lane_strb_o = strb_base << iss_adr_i[2:0];

  // Zeros fill from the top, which covers the fetch rule past the end.
  assign rd_shift = rd_word_i >> {rd_off_i, 3'b000};

  always_comb begin
    sext = 1'b0;
    if (rd_instr_i) begin
      rd_data_o = {{(XLEN-32){1'b0}}, rd_shift[31:0]};  // Four bytes, zero extended.
    end else begin
      case (rd_size_i)
        BYTE: begin
          sext      = ~rd_unsigned_i & rd_shift[7];
          rd_data_o = {{(XLEN-8){sext}}, rd_shift[7:0]};
        end
        HWORD: begin
          sext      = ~rd_unsigned_i & rd_shift[15];
          rd_data_o = {{(XLEN-16){sext}}, rd_shift[15:0]};
        end
        WORD: begin
          sext      = ~rd_unsigned_i & rd_shift[31];
          rd_data_o = {{(XLEN-32){sext}}, rd_shift[31:0]};
        end
        DWORD:   rd_data_o = rd_shift;  // Full width, nothing to extend.
        default: rd_data_o = '0;
      endcase
    end
  end

endmodule

// File: verilog/mem_misalign_check.sv
// --------------------------------------------------
// Memory misalignment check
// Flags a granted access whose address does not fit
// its size, one cycle after issue.
// --------------------------------------------------

`timescale 1ns/1ns

module mem_misalign_check
  import mem_subsys_pkg::*;
#(
  parameter int HAS_RVC = 1  // Compressed instructions allowed.
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              instr_i,       // Access is an instruction fetch.
  input  logic              req_i,         // Issued access is valid.
  input  logic [XLEN-1:0]   adr_i,
  input  access_size_e      size_i,
  output logic              misaligned_o
);

  logic misaligned;  // Raw alignment verdict.

  always_comb begin
    if (instr_i) begin
      // Halfword steps with RVC, whole words without.
      misaligned = (HAS_RVC != 0) ? adr_i[0] : |adr_i[1:0];
    end else begin
      case (size_i)
        BYTE:    misaligned = 1'b0;         // Any byte address works.
        HWORD:   misaligned = adr_i[0];
        WORD:    misaligned = |adr_i[1:0];
        DWORD:   misaligned = |adr_i[2:0];
        default: misaligned = 1'b1;         // Illegal size code.
      endcase
    end
  end

  // Registered so the flag lines up with the memory capture stage.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      misaligned_o <= 1'b0;
    end else begin
      misaligned_o <= req_i & misaligned;
    end
  end

endmodule

// File: verilog/mem_port_arbiter.sv
// --------------------------------------------------
// Memory port arbiter
// Round-robin grant between the fetch and data
// ports into a one-entry issue register.
// --------------------------------------------------

`timescale 1ns/1ns

module mem_port_arbiter
  import mem_subsys_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,

  // Fetch port request, held until acknowledged.
  input  logic              fetch_req_i,
  input  logic [XLEN-1:0]   fetch_adr_i,

  // Data port request, held until acknowledged.
  input  logic              data_req_i,
  input  logic              data_we_i,
  input  logic              data_unsigned_i,
  input  access_size_e      data_size_i,
  input  logic [XLEN-1:0]   data_adr_i,
  input  logic [XLEN-1:0]   data_wdata_i,

  // Acknowledges from the memory.
  input  logic              fetch_ack_i,
  input  logic              data_ack_i,

  // Issued access.
  output logic              iss_valid_o,
  output logic              iss_instr_o,
  output logic              iss_we_o,
  output logic              iss_unsigned_o,
  output access_size_e      iss_size_o,
  output logic [XLEN-1:0]   iss_adr_o,
  output logic [XLEN-1:0]   iss_wdata_o
);

  logic       fetch_busy;   // Fetch access in flight.
  logic       data_busy;    // Data access in flight.
  logic       fetch_elig;
  logic       data_elig;
  logic       tie;          // Both ports eligible this cycle.
  logic       grant_fetch;
  logic       grant_data;
  arb_state_e favor;        // Winner of the next tie.

  // A port is eligible only while it has nothing in flight.
  assign fetch_elig = fetch_req_i & ~fetch_busy;
  assign data_elig  = data_req_i & ~data_busy;
  assign tie        = fetch_elig & data_elig;

  always_comb begin
    grant_fetch = fetch_elig & (~data_elig | (favor == FAVOR_FETCH));
    grant_data  = data_elig & ~grant_fetch;
  end

  // Control state.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      iss_valid_o <= 1'b0;
      fetch_busy  <= 1'b0;
      data_busy   <= 1'b0;
      favor       <= FAVOR_FETCH;
    end else begin
      iss_valid_o <= grant_fetch | grant_data;

      if (grant_fetch) begin
        fetch_busy <= 1'b1;
      end else if (fetch_ack_i) begin
        fetch_busy <= 1'b0;  // Freed in the ack cycle.
      end

      if (grant_data) begin
        data_busy <= 1'b1;
      end else if (data_ack_i) begin
        data_busy <= 1'b0;
      end

      // The loser of a tie wins the next one.
      if (tie) begin
        favor <= (favor == FAVOR_FETCH) ? FAVOR_DATA : FAVOR_FETCH;
      end
    end
  end

  // Issue payload, loaded only on a grant.
  always_ff @(posedge clk_i) begin
    if (grant_fetch) begin
      iss_instr_o    <= 1'b1;
      iss_we_o       <= 1'b0;        // Fetches never write.
      iss_unsigned_o <= 1'b1;        // Zero extended.
      iss_size_o     <= WORD;        // One 32-bit parcel.
      iss_adr_o      <= fetch_adr_i;
      iss_wdata_o    <= '0;
    end else if (grant_data) begin
      iss_instr_o    <= 1'b0;
      iss_we_o       <= data_we_i;
      iss_unsigned_o <= data_unsigned_i;
      iss_size_o     <= data_size_i;
      iss_adr_o      <= data_adr_i;
      iss_wdata_o    <= data_wdata_i;
    end
  end

endmodule

// File: verilog/mem_sram.sv
// --------------------------------------------------
// Memory array with capture stage
// Registers the issued access, reads the array and
// returns ack, data and error to the owning port.
// --------------------------------------------------

`timescale 1ns/1ns

module mem_sram
  import mem_subsys_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,

  // Issued access.
  input  logic              iss_valid_i,
  input  logic              iss_instr_i,
  input  logic              iss_we_i,
  input  logic              iss_unsigned_i,
  input  access_size_e      iss_size_i,
  input  logic [XLEN-1:0]   iss_adr_i,
  input  logic [XLEN-1:0]   lane_wdata_i,
  input  logic [7:0]        lane_strb_i,

  input  logic              misaligned_i,   // Verdict for the captured access.
  input  logic [XLEN-1:0]   rd_data_i,      // Extracted result from the lane unit.

  // To the lane unit.
  output logic [XLEN-1:0]   rd_word_o,
  output access_size_e      rd_size_o,
  output logic [2:0]        rd_off_o,
  output logic              rd_instr_o,
  output logic              rd_unsigned_o,

  // Port responses.
  output logic              fetch_ack_o,
  output logic [XLEN-1:0]   fetch_rdata_o,
  output logic              fetch_err_o,
  output logic              data_ack_o,
  output logic [XLEN-1:0]   data_rdata_o,
  output logic              data_err_o
);

  logic [XLEN-1:0]  mem [MEM_WORDS];  // Doubleword array.
  logic             cap_valid;
  logic             cap_we;
  logic [IDX_W-1:0] cap_idx;
  logic [XLEN-1:0]  cap_wdata;
  logic [7:0]       cap_strb;
  logic             ok;                // Captured access is good.

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= iss_valid_i;
    end
  end

  // Captured payload, valid only with cap_valid.
  always_ff @(posedge clk_i) begin
    rd_instr_o    <= iss_instr_i;
    rd_unsigned_o <= iss_unsigned_i;
    rd_size_o     <= iss_size_i;
    rd_off_o      <= iss_adr_i[2:0];
    cap_we        <= iss_we_i;
    cap_idx       <= iss_adr_i[IDX_W+2:3];  // Address bits 10:3.
    cap_wdata     <= lane_wdata_i;
    cap_strb      <= lane_strb_i;
  end

  assign rd_word_o = mem[cap_idx];
  assign ok        = cap_valid & ~misaligned_i;

  // Byte-strobed write at the end of the ack cycle.
  always_ff @(posedge clk_i) begin
    if (ok && cap_we) begin
      for (int b = 0; b < 8; b++) begin
        if (cap_strb[b]) mem[cap_idx][8*b +: 8] <= cap_wdata[8*b +: 8];
      end
    end
  end

  // Steer the response by the captured instr flag.
  assign fetch_ack_o   = cap_valid & rd_instr_o;
  assign fetch_err_o   = fetch_ack_o & misaligned_i;
  assign fetch_rdata_o = (ok && rd_instr_o) ? rd_data_i : '0;  // Zero on error.
  assign data_ack_o    = cap_valid & ~rd_instr_o;
  assign data_err_o    = data_ack_o & misaligned_i;
  assign data_rdata_o  = (ok && !rd_instr_o) ? rd_data_i : '0;

endmodule

// File: verilog/mem_subsys_pkg.sv
// --------------------------------------------------
// Memory subsystem package
// Geometry constants, access size codes and the
// arbiter favor states shared by the memory blocks.
// --------------------------------------------------

package mem_subsys_pkg;

  // Data and address width of the RV64 core.
  localparam int XLEN = 64;

  // Doubleword count of the single-ported memory.
  localparam int MEM_WORDS = 256;

  // Doubleword index, taken from address bits 10:3.
  localparam int IDX_W = 8;

  // Width of an access, as carried on the size bus.
  // Codes 4 to 7 are illegal and never align.
  typedef enum logic [2:0] {
    BYTE  = 3'd0,  // 8 bits.
    HWORD = 3'd1,  // 16 bits.
    WORD  = 3'd2,  // 32 bits.
    DWORD = 3'd3   // 64 bits.
  } access_size_e;

  // Port that wins the next tie in the arbiter.
  typedef enum logic {
    FAVOR_FETCH = 1'b0,
    FAVOR_DATA  = 1'b1
  } arb_state_e;

endpackage

// File: verilog/mem_subsys_top.sv
// --------------------------------------------------
// Shared memory subsystem
// Fetch and data ports share one memory through a
// round-robin arbiter and an alignment check.
// --------------------------------------------------

`timescale 1ns/1ns

module mem_subsys_top
  import mem_subsys_pkg::*;
#(
  parameter int HAS_RVC = 1
) (
  input  logic              clk_i,
  input  logic              rst_n_i,

  // Instruction fetch port.
  input  logic              fetch_req_i,
  input  logic [XLEN-1:0]   fetch_adr_i,
  output logic              fetch_ack_o,
  output logic [XLEN-1:0]   fetch_rdata_o,
  output logic              fetch_err_o,

  // Load/store port.
  input  logic              data_req_i,
  input  logic              data_we_i,
  input  logic              data_unsigned_i,
  input  access_size_e      data_size_i,
  input  logic [XLEN-1:0]   data_adr_i,
  input  logic [XLEN-1:0]   data_wdata_i,
  output logic              data_ack_o,
  output logic [XLEN-1:0]   data_rdata_o,
  output logic              data_err_o
);

  // Issue register outputs.
  logic            iss_valid;
  logic            iss_instr;
  logic            iss_we;
  logic            iss_unsigned;
  access_size_e    iss_size;
  logic [XLEN-1:0] iss_adr;
  logic [XLEN-1:0] iss_wdata;

  logic            misaligned;
  logic [XLEN-1:0] lane_wdata;
  logic [7:0]      lane_strb;

  // Capture stage back to the lane unit.
  logic [XLEN-1:0] rd_word;
  access_size_e    rd_size;
  logic [2:0]      rd_off;
  logic            rd_instr;
  logic            rd_unsigned;
  logic [XLEN-1:0] rd_data;

  mem_port_arbiter u_arbiter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch_req_i     (fetch_req_i),
    .fetch_adr_i     (fetch_adr_i),
    .data_req_i      (data_req_i),
    .data_we_i       (data_we_i),
    .data_unsigned_i (data_unsigned_i),
    .data_size_i     (data_size_i),
    .data_adr_i      (data_adr_i),
    .data_wdata_i    (data_wdata_i),
    .fetch_ack_i     (fetch_ack_o),
    .data_ack_i      (data_ack_o),
    .iss_valid_o     (iss_valid),
    .iss_instr_o     (iss_instr),
    .iss_we_o        (iss_we),
    .iss_unsigned_o  (iss_unsigned),
    .iss_size_o      (iss_size),
    .iss_adr_o       (iss_adr),
    .iss_wdata_o     (iss_wdata)
  );

  mem_misalign_check #(
    .HAS_RVC (HAS_RVC)
  ) u_check (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .instr_i      (iss_instr),
    .req_i        (iss_valid),
    .adr_i        (iss_adr),
    .size_i       (iss_size),
    .misaligned_o (misaligned)
  );

  mem_data_lane u_lane (
    .iss_size_i    (iss_size),
    .iss_adr_i     (iss_adr),
    .iss_wdata_i   (iss_wdata),
    .rd_word_i     (rd_word),
    .rd_size_i     (rd_size),
    .rd_off_i      (rd_off),
    .rd_instr_i    (rd_instr),
    .rd_unsigned_i (rd_unsigned),
    .lane_wdata_o  (lane_wdata),
    .lane_strb_o   (lane_strb),
    .rd_data_o     (rd_data)
  );

  mem_sram u_sram (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .iss_valid_i    (iss_valid),
    .iss_instr_i    (iss_instr),
    .iss_we_i       (iss_we),
    .iss_unsigned_i (iss_unsigned),
    .iss_size_i     (iss_size),
    .iss_adr_i      (iss_adr),
    .lane_wdata_i   (lane_wdata),
    .lane_strb_i    (lane_strb),
    .misaligned_i   (misaligned),
    .rd_data_i      (rd_data),
    .rd_word_o      (rd_word),
    .rd_size_o      (rd_size),
    .rd_off_o       (rd_off),
    .rd_instr_o     (rd_instr),
    .rd_unsigned_o  (rd_unsigned),
    .fetch_ack_o    (fetch_ack_o),
    .fetch_rdata_o  (fetch_rdata_o),
    .fetch_err_o    (fetch_err_o),
    .data_ack_o     (data_ack_o),
    .data_rdata_o   (data_rdata_o),
    .data_err_o     (data_err_o)
  );

endmodule
